//--- Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= nf_tb
FLIST     ?= nf_periph.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TEST PASSED

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run passes only if the pass string shows up in the output
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

//--- nf_clock_div.sv
`timescale 1ns/1ns

module nf_clock_div
(
    input   logic                           clk,                // clock
    input   logic                           arst_n,             // async reset, low
    input   logic   [nf_pkg::DIV_W-1 : 0]   div,                // divide value
    output  logic                           en                  // one cycle strobe
);

    logic   [nf_pkg::DIV_W-1 : 0]   cnt;                        // down counter

    // reload on zero, so one pulse every div+1 clocks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            cnt <= '0;
        else if (cnt == '0)
            cnt <= div;                                         // div 0 keeps it at zero
        else
            cnt <= cnt - 1'b1;
    end

    assign en = (cnt == '0);                                    // strobe at terminal count

endmodule : nf_clock_div

//--- nf_gpio.sv
`timescale 1ns/1ns

module nf_gpio
#(
    parameter int gpio_w = 8                                    // pin count
)
(
    // clock and reset
    input   logic                   clk,                        // clock
    input   logic                   arst_n,                     // async reset, low
    // router side
    input   nf_pkg::apb_req_t       req,                        // apb request
    output  nf_pkg::apb_rsp_t       rsp,                        // apb response
    // pin side
    input   logic   [gpio_w-1 : 0]  gpi,                        // raw input pins
    output  logic   [gpio_w-1 : 0]  gpo,                        // output register
    output  logic   [gpio_w-1 : 0]  gpd                         // direction register
);

    logic   [gpio_w-1 : 0]              gpi_meta;               // first sync stage
    logic   [gpio_w-1 : 0]              gpi_sync;               // second sync stage
    logic   [nf_pkg::SEL_LSB-1 : 0]     offset;                 // register offset
    logic                               wr_acc;                 // write access phase

    assign offset = req.paddr[nf_pkg::SEL_LSB-1 : 0];
    assign wr_acc = req.psel && req.penable && req.pwrite;

    // two flops on the async pins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpi_meta <= '0;
            gpi_sync <= '0;
        end else begin
            gpi_meta <= gpi;
            gpi_sync <= gpi_meta;
        end
    end

    // gpo and gpd writable, gpi writes dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpo <= '0;
            gpd <= '0;
        end else if (wr_acc) begin
            case (offset)
                nf_pkg::GPIO_GPO : gpo <= req.pwdata[gpio_w-1 : 0];
                nf_pkg::GPIO_GPD : gpd <= req.pwdata[gpio_w-1 : 0];
                default          : ;                            // gpi and holes ignored
            endcase
        end
    end

    // readback, zero extended
    always_comb begin
        rsp         = '0;
        rsp.pready  = 1'b1;
        if (req.psel && !req.pwrite) begin
            case (offset)
                nf_pkg::GPIO_GPI : rsp.prdata = nf_pkg::DATA_W'(gpi_sync);
                nf_pkg::GPIO_GPO : rsp.prdata = nf_pkg::DATA_W'(gpo);
                nf_pkg::GPIO_GPD : rsp.prdata = nf_pkg::DATA_W'(gpd);
                default          : rsp.prdata = '0;
            endcase
        end
    end

endmodule : nf_gpio

//--- nf_periph.f
nf_pkg.sv
nf_router.sv
nf_ram.sv
nf_gpio.sv
nf_clock_div.sv
nf_pwm.sv
nf_top.sv
nf_tb.sv

//--- nf_pkg.sv
package nf_pkg;

    // bus widths
    localparam int ADDR_W   = 32;                       // apb address width
    localparam int DATA_W   = 32;                       // apb data width
    localparam int DIV_W    = 26;                       // clock divider input width

    // address map, slot picked by paddr[SEL_MSB:SEL_LSB]
    localparam int SLAVE_N  = 4;                        // decoded device slots
    localparam int SEL_LSB  = 12;                       // low slot select bit
    localparam int SEL_MSB  = 13;                       // high slot select bit

    localparam int SLOT_RAM  = 0;                       // word ram
    localparam int SLOT_GPIO = 1;                       // gpio registers
    localparam int SLOT_PWM  = 2;                       // pwm generator
    localparam int SLOT_NONE = 3;                       // unmapped, router answers

    // register offsets inside a slot
    localparam logic [SEL_LSB-1 : 0] GPIO_GPI = 12'h000;    // synced input, read only
    localparam logic [SEL_LSB-1 : 0] GPIO_GPO = 12'h004;    // output register
    localparam logic [SEL_LSB-1 : 0] GPIO_GPD = 12'h008;    // direction register
    localparam logic [SEL_LSB-1 : 0] PWM_DUTY = 12'h000;    // duty register

    // apb request, master to slave
    typedef struct packed {
        logic   [ADDR_W-1 : 0]  paddr;                  // byte address
        logic                   psel;                   // slave select
        logic                   penable;                // access phase
        logic                   pwrite;                 // 1 write, 0 read
        logic   [DATA_W-1 : 0]  pwdata;                 // write data
    } apb_req_t;

    // apb response, slave to master
    typedef struct packed {
        logic   [DATA_W-1 : 0]  prdata;                 // read data
        logic                   pready;                 // transfer done
        logic                   pslverr;                // error on transfer
    } apb_rsp_t;

endpackage : nf_pkg

//--- nf_pwm.sv
`timescale 1ns/1ns

module nf_pwm
#(
    parameter int pwm_width = 8                                 // counter and duty width
)
(
    // clock and reset
    input   logic               clk,                            // clock
    input   logic               arst_n,                         // async reset, low
    // router side
    input   nf_pkg::apb_req_t   req,                            // apb request
    output  nf_pkg::apb_rsp_t   rsp,                            // apb response
    // pwm side
    input   logic               en,                             // counter step strobe
    output  logic               pwm                             // pwm output
);

    logic   [pwm_width-1 : 0]           duty;                   // high time in steps
    logic   [pwm_width-1 : 0]           cnt;                    // free running counter
    logic   [nf_pkg::SEL_LSB-1 : 0]     offset;                 // register offset
    logic                               duty_hit;               // duty reg addressed

    assign offset   = req.paddr[nf_pkg::SEL_LSB-1 : 0];
    assign duty_hit = req.psel && (offset == nf_pkg::PWM_DUTY);

    // duty write on access edge, only the low bits kept
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            duty <= '0;
        else if (duty_hit && req.penable && req.pwrite)
            duty <= req.pwdata[pwm_width-1 : 0];
    end

    // counter wraps at 2**pwm_width
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            cnt <= '0;
        else if (en)
            cnt <= cnt + 1'b1;
    end

    // output one clock behind the compare
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pwm <= 1'b0;
        else
            pwm <= (cnt < duty);
    end

    always_comb begin
        rsp         = '0;
        rsp.pready  = 1'b1;
        if (duty_hit && !req.pwrite)
            rsp.prdata = nf_pkg::DATA_W'(duty);                 // upper bits read zero
    end

endmodule : nf_pwm

//--- nf_ram.sv
`timescale 1ns/1ns

module nf_ram
#(
    parameter int depth = 64                                    // words, power of two
)
(
    input   logic               clk,                            // clock
    input   nf_pkg::apb_req_t   req,                            // apb request
    output  nf_pkg::apb_rsp_t   rsp                             // apb response
);

    localparam int Idx_w = $clog2(depth);

    logic   [nf_pkg::DATA_W-1 : 0]  mem [depth];                // word storage
    logic   [Idx_w-1 : 0]           idx;                        // word index
    logic                           wr_acc;                     // write access phase
    logic                           rd_sel;                     // read transfer

    // byte offset dropped, upper bits wrap modulo depth
    assign idx    = req.paddr[Idx_w+1 : 2];
    assign wr_acc = req.psel && req.penable && req.pwrite;
    assign rd_sel = req.psel && !req.pwrite;

    // write lands on the access edge
    always_ff @(posedge clk) begin
        if (wr_acc)
            mem[idx] <= req.pwdata;
    end

    // read data straight from the array
    always_comb begin
        rsp         = '0;
        rsp.pready  = 1'b1;                                     // zero wait states
        if (rd_sel)
            rsp.prdata = mem[idx];
    end

    // an unknown address would read or corrupt a random word
    a_addr_known : assert property (
        @(posedge clk)
        req.psel |-> !$isunknown(req.paddr)
    ) else $error("ram: unknown address while selected");

endmodule : nf_ram

//--- nf_router.sv
`timescale 1ns/1ns

module nf_router
#(
    parameter int Slave_n = 4                                   // decoded slots
)
(
    // clock and reset
    input   logic                                   clk,        // clock
    input   logic                                   arst_n,     // async reset, low
    // master side
    input   nf_pkg::apb_req_t                       req_m,      // request from master
    output  nf_pkg::apb_rsp_t                       rsp_m,      // response to master
    // devices side
    output  nf_pkg::apb_req_t   [Slave_n-1 : 0]     req_s,      // request per slot
    input   nf_pkg::apb_rsp_t   [Slave_n-1 : 0]     rsp_s       // response per slot
);

    localparam int Sel_w = nf_pkg::SEL_MSB - nf_pkg::SEL_LSB + 1;

    logic   [Sel_w-1   : 0]     slot;                           // decoded slot number
    nf_pkg::apb_rsp_t           err_rsp;                        // unmapped slot answer

    assign slot = req_m.paddr[nf_pkg::SEL_MSB : nf_pkg::SEL_LSB];

    // fan out, only the addressed slot sees psel
    always_comb begin
        for (int i = 0; i < Slave_n; i++) begin
            req_s[i]      = req_m;                              // shared addr, data, ctrl
            req_s[i].psel = req_m.psel && (slot == Sel_w'(i));  // gate select
        end
    end

    // error answer for the hole in the map
    always_comb begin
        err_rsp         = '0;
        err_rsp.pready  = 1'b1;                                 // no wait states
        err_rsp.pslverr = req_m.penable;                        // flag in access phase
    end

    // response mux, idle bus looks ready and clean
    always_comb begin
        rsp_m         = '0;
        rsp_m.pready  = 1'b1;
        if (req_m.psel) begin
            if (slot == Sel_w'(nf_pkg::SLOT_NONE))
                rsp_m = err_rsp;                                // unmapped slot
            else
                rsp_m = rsp_s[slot];                            // selected device
        end
    end

    // access phase only inside a selected transfer
    a_penable_psel : assert property (
        @(posedge clk) disable iff (!arst_n)
        req_m.penable |-> req_m.psel
    ) else $error("router: penable without psel");

endmodule : nf_router

//--- nf_tb.sv
`timescale 1ns/1ns

module nf_tb;

    localparam int ram_depth = 64;                              // ram words
    localparam int gpio_w    = 8;                               // gpio pins
    localparam int pwm_width = 8;                               // pwm resolution
    localparam int div_val   = 3;                               // pwm step every 4 clocks
    localparam int win_len   = (2 ** pwm_width) * (div_val + 1);  // one pwm period in clocks
    localparam int duty_hi   = 64;                              // second duty value

    localparam logic [31:0]        gpo_wr  = 32'hdead_be5a;     // upper bits must drop
    localparam logic [31:0]        gpd_wr  = 32'h0000_003c;
    localparam logic [gpio_w-1:0]  gpo_exp = gpo_wr[gpio_w-1:0];
    localparam logic [gpio_w-1:0]  gpd_exp = gpd_wr[gpio_w-1:0];
    localparam logic [gpio_w-1:0]  gpi_val = 8'h96;             // driven on the pins

    // one table row, a single apb transfer
    typedef struct packed {
        logic           wr;                                     // 1 write, 0 read
        logic [31:0]    addr;                                   // byte address
        logic [31:0]    wdata;                                  // write data
        logic [31:0]    rdata;                                  // expected prdata
        logic           chk_rd;                                 // compare prdata
        logic           slverr;                                 // expected pslverr
    } entry_t;

    logic                           clk;
    logic                           arst_n;
    logic   [nf_pkg::DIV_W-1 : 0]   div;
    nf_pkg::apb_req_t               req;
    nf_pkg::apb_rsp_t               rsp;
    logic                           pwm;
    logic   [gpio_w-1 : 0]          gpi;
    logic   [gpio_w-1 : 0]          gpo;
    logic   [gpio_w-1 : 0]          gpd;

    entry_t                         stim_q [$];                 // stimulus table
    int                             seed;                       // $random state

    nf_top #(
        .ram_depth  ( ram_depth     ),
        .gpio_w     ( gpio_w        ),
        .pwm_width  ( pwm_width     )
    ) dut_i (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .div        ( div           ),
        .req        ( req           ),
        .rsp        ( rsp           ),
        .pwm        ( pwm           ),
        .gpi        ( gpi           ),
        .gpo        ( gpo           ),
        .gpd        ( gpd           )
    );

    always #4 clk = ~clk;                                       // 8 ns period

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    function automatic logic [31:0] slot_addr(input int slot,
                                              input logic [nf_pkg::SEL_LSB-1 : 0] offs);
        return (32'(slot) << nf_pkg::SEL_LSB) | 32'(offs);      // slot in bits 13:12
    endfunction

    function automatic void add_entry(input logic wr, input logic [31:0] addr,
                                      input logic [31:0] wdata, input logic [31:0] rdata,
                                      input logic chk_rd, input logic slverr);
        entry_t e;
        e.wr     = wr;
        e.addr   = addr;
        e.wdata  = wdata;
        e.rdata  = rdata;
        e.chk_rd = chk_rd;
        e.slverr = slverr;
        stim_q.push_back(e);
    endfunction

    // prdata only compared where the bus defines it
    task automatic check_rsp(input nf_pkg::apb_rsp_t got, input nf_pkg::apb_rsp_t want,
                             input logic chk_rd, input string what);
        if (got.pslverr !== want.pslverr || (chk_rd && got.prdata !== want.prdata))
            report_mismatch($sformatf("%s: prdata %h pslverr %b, expected prdata %h pslverr %b",
                            what, got.prdata, got.pslverr, want.prdata, want.pslverr));
    endtask

    task automatic check_pins(input logic [gpio_w-1 : 0] want_gpo,
                              input logic [gpio_w-1 : 0] want_gpd, input logic want_pwm);
        if (gpo !== want_gpo || gpd !== want_gpd || pwm !== want_pwm)
            report_mismatch($sformatf("pins gpo %h gpd %h pwm %b, expected %h %h %b",
                            gpo, gpd, pwm, want_gpo, want_gpd, want_pwm));
    endtask

    task automatic check_high_time(input int got, input int want, input string what);
        if (got != want)
            report_mismatch($sformatf("%s: %0d high cycles, expected %0d", what, got, want));
    endtask

    // setup then access, completes on the edge after pready seen
    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata, output nf_pkg::apb_rsp_t got);
        nf_pkg::apb_req_t r;
        r        = '0;
        r.paddr  = addr;
        r.psel   = 1'b1;
        r.pwrite = wr;
        r.pwdata = wdata;
        @(posedge clk);
        req <= r;                                               // setup phase
        r.penable = 1'b1;
        @(posedge clk);
        req <= r;                                               // access phase
        @(negedge clk);
        while (!rsp.pready)
            @(negedge clk);
        got = rsp;                                              // stable mid cycle
        @(posedge clk);
        req <= '0;                                              // back to idle
    endtask

    // sampled mid cycle, away from the edges
    task automatic count_pwm_high(input int cycles, output int high);
        high = 0;
        repeat (cycles) begin
            @(negedge clk);
            if ($isunknown(pwm))
                report_mismatch("pwm output unknown");
            if (pwm)
                high++;
        end
    endtask

    task automatic build_table();
        logic [11:0] ram_a [4];
        logic [31:0] ram_d [4];
        ram_a = '{12'h000, 12'h004, 12'h014, 12'h0fc};          // last one is word 63
        for (int i = 0; i < 4; i++) begin
            ram_d[i] = $random(seed);
            add_entry(1'b1, slot_addr(nf_pkg::SLOT_RAM, ram_a[i]), ram_d[i], '0, 1'b0, 1'b0);
        end
        for (int i = 0; i < 4; i++)
            add_entry(1'b0, slot_addr(nf_pkg::SLOT_RAM, ram_a[i]), '0, ram_d[i], 1'b1, 1'b0);
        // word depth+5 wraps onto word 5
        add_entry(1'b0, slot_addr(nf_pkg::SLOT_RAM, 12'((ram_depth + 5) * 4)), '0,
                  ram_d[2], 1'b1, 1'b0);
        // gpio registers, zero extended on read
        add_entry(1'b1, slot_addr(nf_pkg::SLOT_GPIO, nf_pkg::GPIO_GPO), gpo_wr, '0, 1'b0, 1'b0);
        add_entry(1'b1, slot_addr(nf_pkg::SLOT_GPIO, nf_pkg::GPIO_GPD), gpd_wr, '0, 1'b0, 1'b0);
        add_entry(1'b0, slot_addr(nf_pkg::SLOT_GPIO, nf_pkg::GPIO_GPO), '0, 32'(gpo_exp),
                  1'b1, 1'b0);
        add_entry(1'b0, slot_addr(nf_pkg::SLOT_GPIO, nf_pkg::GPIO_GPD), '0, 32'(gpd_exp),
                  1'b1, 1'b0);
        add_entry(1'b1, slot_addr(nf_pkg::SLOT_GPIO, nf_pkg::GPIO_GPI), '1, '0, 1'b0, 1'b0);
        add_entry(1'b0, slot_addr(nf_pkg::SLOT_GPIO, nf_pkg::GPIO_GPI), '0, '0, 1'b1, 1'b0);
        add_entry(1'b0, slot_addr(nf_pkg::SLOT_GPIO, nf_pkg::GPIO_GPO), '0, 32'(gpo_exp),
                  1'b1, 1'b0);
        add_entry(1'b0, slot_addr(nf_pkg::SLOT_GPIO, nf_pkg::GPIO_GPD), '0, 32'(gpd_exp),
                  1'b1, 1'b0);
        // hole in the map, ram word 5 must survive
        add_entry(1'b1, slot_addr(nf_pkg::SLOT_NONE, 12'h014), 32'h1234_5678, '0, 1'b1, 1'b1);
        add_entry(1'b0, slot_addr(nf_pkg::SLOT_NONE, 12'h014), '0, '0, 1'b1, 1'b1);
        add_entry(1'b0, slot_addr(nf_pkg::SLOT_RAM, 12'h014), '0, ram_d[2], 1'b1, 1'b0);
    endtask

    task automatic run_table();
        nf_pkg::apb_rsp_t got;
        nf_pkg::apb_rsp_t want;
        foreach (stim_q[i]) begin
            apb_transfer(stim_q[i].wr, stim_q[i].addr, stim_q[i].wdata, got);
            want         = '0;
            want.pready  = 1'b1;
            want.prdata  = stim_q[i].rdata;
            want.pslverr = stim_q[i].slverr;
            check_rsp(got, want, stim_q[i].chk_rd,
                      $sformatf("entry %0d addr %h", i, stim_q[i].addr));
        end
    endtask

    initial begin : main
        nf_pkg::apb_rsp_t got;
        nf_pkg::apb_rsp_t want;
        int high;
        clk    = 1'b0;
        arst_n = 1'b0;
        div    = nf_pkg::DIV_W'(div_val);
        req    = '0;
        gpi    = '0;
        seed   = 32'h1a2ec172;
        build_table();
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_pins('0, '0, 1'b0);                               // reset state
        want        = '0;
        want.pready = 1'b1;
        check_rsp(rsp, want, 1'b1, "idle bus after reset");
        apb_transfer(1'b1, slot_addr(nf_pkg::SLOT_PWM, nf_pkg::PWM_DUTY), '0, got);
        check_rsp(got, want, 1'b0, "duty 0 write");
        // zero duty window runs beside the bus tests
        fork
            begin
                count_pwm_high(win_len, high);
                check_high_time(high, 0, "duty 0 window");
            end
            begin
                run_table();
                @(negedge clk);
                check_pins(gpo_exp, gpd_exp, 1'b0);
                @(posedge clk);
                gpi <= gpi_val;
                repeat (3) @(posedge clk);                      // two sync flops plus margin
                apb_transfer(1'b0, slot_addr(nf_pkg::SLOT_GPIO, nf_pkg::GPIO_GPI), '0, got);
                want.prdata = 32'(gpi_val);
                check_rsp(got, want, 1'b1, "gpi readback");
            end
        join
        want.prdata = '0;
        apb_transfer(1'b1, slot_addr(nf_pkg::SLOT_PWM, nf_pkg::PWM_DUTY), 32'(duty_hi), got);
        check_rsp(got, want, 1'b0, "duty write");
        repeat (win_len) @(posedge clk);                        // one full period settles
        count_pwm_high(win_len, high);
        check_high_time(high, duty_hi * (div_val + 1), "duty 64 window");
        apb_transfer(1'b0, slot_addr(nf_pkg::SLOT_PWM, nf_pkg::PWM_DUTY), '0, got);
        want.prdata = 32'(duty_hi);
        check_rsp(got, want, 1'b1, "duty readback");
        $display("TEST PASSED");
        $finish;
    end

    // budget from table size and two pwm periods
    initial begin : watchdog
        int limit;
        wait (arst_n === 1'b1);
        limit = stim_q.size() * 4 + 2 * win_len + 1000;
        repeat (limit) @(posedge clk);
        $display("TEST FAILED");
        $fatal(1, "timeout, the run did not finish within %0d cycles", limit);
    end

endmodule : nf_tb

//--- nf_top.sv
`timescale 1ns/1ns

module nf_top
#(
    parameter int ram_depth = 64,                               // ram words
    parameter int gpio_w    = 8,                                // gpio pins
    parameter int pwm_width = 8                                 // pwm resolution
)
(
    // clock and reset
    input   logic                           clk,                // clock
    input   logic                           arst_n,             // async reset, low
    input   logic   [nf_pkg::DIV_W-1 : 0]   div,                // pwm step divider
    // apb master side
    input   nf_pkg::apb_req_t               req,                // bus request
    output  nf_pkg::apb_rsp_t               rsp,                // bus response
    // pwm side
    output  logic                           pwm,                // pwm output
    // gpio side
    input   logic   [gpio_w-1 : 0]          gpi,                // gpio input
    output  logic   [gpio_w-1 : 0]          gpo,                // gpio output
    output  logic   [gpio_w-1 : 0]          gpd                 // gpio direction
);

    nf_pkg::apb_req_t   [nf_pkg::SLAVE_N-1 : 0]     req_s;      // per slot requests
    nf_pkg::apb_rsp_t   [nf_pkg::SLAVE_N-1 : 0]     rsp_s;      // per slot responses
    logic                                           pwm_en;     // divider strobe

    assign rsp_s[nf_pkg::SLOT_NONE] = '0;                       // hole, router answers

    nf_router #(
        .Slave_n    ( nf_pkg::SLAVE_N               )
    ) nf_router_0 (
        .clk        ( clk                           ),
        .arst_n     ( arst_n                        ),
        .req_m      ( req                           ),
        .rsp_m      ( rsp                           ),
        .req_s      ( req_s                         ),
        .rsp_s      ( rsp_s                         )
    );

    nf_ram #(
        .depth      ( ram_depth                     )
    ) nf_ram_0 (
        .clk        ( clk                           ),
        .req        ( req_s[nf_pkg::SLOT_RAM]       ),
        .rsp        ( rsp_s[nf_pkg::SLOT_RAM]       )
    );

    nf_gpio #(
        .gpio_w     ( gpio_w                        )
    ) nf_gpio_0 (
        .clk        ( clk                           ),
        .arst_n     ( arst_n                        ),
        .req        ( req_s[nf_pkg::SLOT_GPIO]      ),
        .rsp        ( rsp_s[nf_pkg::SLOT_GPIO]      ),
        .gpi        ( gpi                           ),
        .gpo        ( gpo                           ),
        .gpd        ( gpd                           )
    );

    // strobe for the pwm counter
    nf_clock_div nf_clock_div_0 (
        .clk        ( clk                           ),
        .arst_n     ( arst_n                        ),
        .div        ( div                           ),
        .en         ( pwm_en                        )
    );

    nf_pwm #(
        .pwm_width  ( pwm_width                     )
    ) nf_pwm_0 (
        .clk        ( clk                           ),
        .arst_n     ( arst_n                        ),
        .req        ( req_s[nf_pkg::SLOT_PWM]       ),
        .rsp        ( rsp_s[nf_pkg::SLOT_PWM]       ),
        .en         ( pwm_en                        ),
        .pwm        ( pwm                           )
    );

endmodule : nf_top
